// ==== build.f ====
design/revo_pkg.sv
design/revo_pulse_catcher.sv
design/revo_stream_sampler.sv
design/revo_window_judge.sv
design/revo_line_encoder.sv
design/revo_encoder_top.sv
verif/revo_encoder_tb.sv

// ==== design/revo_encoder_top.sv ====
`timescale 1ns/1ps

module revo_encoder_top #(
	parameter int sync_stages = 2
) (
	input logic clock2,
	input logic reset,
	input logic revo_in,
	output revo_pkg::line_word_t line_word,
	output logic word_load,
	output logic clock_gate
);

	logic marker;
	revo_pkg::revo_stream_t stream;
	logic trg;
	logic frame_start;

	// async marker into clock2
	revo_pulse_catcher #(
		.sync_stages(sync_stages)
	) i_revo_pulse_catcher (
		.clock2(clock2),
		.reset(reset),
		.revo_in(revo_in),
		.marker(marker)
	);

	revo_stream_sampler i_revo_stream_sampler (
		.clock2(clock2),
		.reset(reset),
		.marker(marker),
		.stream(stream)
	);

	// once-per-frame trigger decision
	revo_window_judge i_revo_window_judge (
		.clock2(clock2),
		.reset(reset),
		.stream(stream),
		.trg(trg),
		.frame_start(frame_start)
	);

	revo_line_encoder i_revo_line_encoder (
		.clock2(clock2),
		.reset(reset),
		.trg(trg),
		.frame_start(frame_start),
		.line_word(line_word),
		.word_load(word_load),
		.clock_gate(clock_gate)
	);

endmodule

// ==== design/revo_line_encoder.sv ====
`timescale 1ns/1ps

module revo_line_encoder (
	input logic clock2,
	input logic reset,
	input logic trg,
	input logic frame_start,
	output revo_pkg::line_word_t line_word,
	output logic word_load,
	output logic clock_gate
);

	// ------------------------------------------------------------------------
	// serializer word, one per frame
	// ------------------------------------------------------------------------

	always_ff @(posedge clock2) begin
		if (reset) begin
			line_word <= revo_pkg::word_null;
			word_load <= 1'b0;
		end else begin
			word_load <= frame_start;
			if (frame_start) begin
				if (trg) begin
					line_word <= revo_pkg::word_trg;
				end else begin
					line_word <= revo_pkg::word_null;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// forwarded clock gate
	// ------------------------------------------------------------------------

	// low blanks the forwarded clock for the trigger frame
	always_ff @(posedge clock2) begin
		if (reset) begin
			clock_gate <= 1'b1;
		end else begin
			clock_gate <= ~trg;
		end
	end

endmodule

// ==== design/revo_pkg.sv ====
package revo_pkg;

	// ------------------------------------------------------------------------
	// marker history geometry
	// ------------------------------------------------------------------------

	// samples kept in the history word
	localparam int stream_width = 16;
	// newest samples, the window a fresh marker must land in
	localparam int window_width = 8;
	// judge frame length in clock2 cycles
	localparam int frame_len = 4;

	// older samples sit in the upper bits, as the sampler shifts left
	typedef struct packed {
		logic [stream_width-window_width-1:0] stale;
		logic [window_width-1:0] recent;
	} revo_halves_t;

	// one history word, seen either as a shift vector or as two windows
	typedef union packed {
		logic [stream_width-1:0] bits;
		revo_halves_t halves;
	} revo_stream_t;

	// ------------------------------------------------------------------------
	// line word patterns
	// ------------------------------------------------------------------------

	typedef logic [7:0] line_word_t;

	// idle pattern, keeps the link transitions going
	localparam line_word_t word_null = 8'b11000000;
	// trigger pattern, inverted shape of the idle word
	localparam line_word_t word_trg = 8'b00111111;

endpackage

// ==== design/revo_pulse_catcher.sv ====
`timescale 1ns/1ps

module revo_pulse_catcher #(
	parameter int sync_stages = 2
) (
	input logic clock2,
	input logic reset,
	input logic revo_in,
	output logic marker
);

	logic capture;
	logic clear;
	logic [sync_stages-1:0] sync_q;

	// release the capture once the marker is out and the input went low
	assign clear = reset | (~revo_in & marker);

	// ------------------------------------------------------------------------
	// capture flop, clocked by the marker itself
	// ------------------------------------------------------------------------

	// catches pulses much shorter than a clock2 period
	always_ff @(posedge revo_in or posedge clear) begin
		if (clear) begin
			capture <= 1'b0;
		end else begin
			capture <= 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// clock2 resync chain plus output register
	// ------------------------------------------------------------------------

	always_ff @(posedge clock2) begin
		if (reset) begin
			sync_q <= '0;
			marker <= 1'b0;
		end else begin
			for (int i = sync_stages - 1; i > 0; i--) begin
				sync_q[i] <= sync_q[i-1];
			end
			// first stage may go metastable, the rest settle it
			sync_q[0] <= capture & ~clear;
			marker <= sync_q[sync_stages-1];
		end
	end

endmodule

// ==== design/revo_stream_sampler.sv ====
`timescale 1ns/1ps

module revo_stream_sampler (
	input logic clock2,
	input logic reset,
	input logic marker,
	output revo_pkg::revo_stream_t stream
);

	localparam int msb = revo_pkg::stream_width - 1;

	// ------------------------------------------------------------------------
	// marker history
	// ------------------------------------------------------------------------

	// bit 0 is the newest sample, the top bit the oldest
	// a pulse walks upward one bit per cycle, so its start and its length
	// can both be read from the word
	always_ff @(posedge clock2) begin
		if (reset) begin
			stream.bits <= '0;
		end else begin
			stream.bits <= {stream.bits[msb-1:0], marker};
		end
	end

	// the judge reads this same word through the halves view
	// no other state is kept here

endmodule

// ==== design/revo_window_judge.sv ====
`timescale 1ns/1ps

module revo_window_judge (
	input logic clock2,
	input logic reset,
	input revo_pkg::revo_stream_t stream,
	output logic trg,
	output logic frame_start
);

	localparam int stale_width = revo_pkg::stream_width - revo_pkg::window_width;

	// one-hot phase ring, bit 0 opens the frame
	logic [revo_pkg::frame_len-1:0] phase;

	// halves latched at phase 0
	logic [stale_width-1:0] stale_q;
	logic [revo_pkg::window_width-1:0] recent_q;

	// reduced activity flags
	logic stale_flag;
	logic recent_flag;

	// decision built over the frame, shown as trg in the next one
	logic pending;

	// ------------------------------------------------------------------------
	// phase ring
	// ------------------------------------------------------------------------

	always_ff @(posedge clock2) begin
		if (reset) begin
			phase <= {{(revo_pkg::frame_len-1){1'b0}}, 1'b1};
		end else begin
			phase <= {phase[revo_pkg::frame_len-2:0], phase[revo_pkg::frame_len-1]};
		end
	end

	// ------------------------------------------------------------------------
	// decision spread over the four phases
	// ------------------------------------------------------------------------

	always_ff @(posedge clock2) begin
		if (reset) begin
			trg <= 1'b0;
			frame_start <= 1'b0;
			stale_q <= '0;
			recent_q <= '0;
			stale_flag <= 1'b0;
			recent_flag <= 1'b0;
			pending <= 1'b0;
		end else begin
			frame_start <= phase[0];
			if (phase[0]) begin
				// publish last frame's verdict, grab a new snapshot
				trg <= pending;
				stale_q <= stream.halves.stale;
				recent_q <= stream.halves.recent;
			end
			if (phase[1]) begin
				stale_flag <= |stale_q;
				recent_flag <= |recent_q;
				pending <= 1'b0;
			end
			if (phase[2]) begin
				// something new arrived in the recent window
				if (recent_flag) begin
					pending <= 1'b1;
				end
			end
			if (phase[3]) begin
				// old activity means a long pulse or a re-trigger, so veto
				if (stale_flag) begin
					pending <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the revo encoder testbench with Verilator

top=revo_encoder_tb
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module "$top" -f build.f -o sim_revo
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

./obj_dir/sim_revo > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$log"; then
	echo "result: FAIL"
	exit 1
fi
if ! grep -q "Verification passed" "$log"; then
	echo "result: FAIL, no final verdict in $log"
	exit 1
fi
echo "result: PASS"
exit 0

// ==== verif/revo_encoder_tb.sv ====
`timescale 1ns/1ps

module revo_encoder_tb;

	localparam int clock_period = 10;
	localparam int reset_cycles = 4;
	localparam int random_pulses = 60;
	// low time that lets the capture flop release before the next marker
	localparam int min_low = 6;
	localparam int max_gap = 40;
	localparam int max_len = 12;
	localparam int directed_cycles = 400;
	localparam int random_cycles = random_pulses * (max_len + min_low + max_gap + 1);
	localparam int limit_cycles = reset_cycles + directed_cycles + random_cycles + 200;

	logic clock2 = 1'b0;
	logic reset;
	logic revo_in;
	revo_pkg::line_word_t line_word;
	logic word_load;
	logic clock_gate;

	// reference model state
	logic [1:0] in_delay;
	logic exp_marker;
	int high_count;
	logic [15:0] exp_stream;
	logic [15:0] snapshot;
	int frame_cycle;
	logic exp_trg;
	logic exp_load;
	logic exp_gate;

	int errors;
	int checks;
	int loads_seen;
	logic [31:0] lfsr_state;

	revo_encoder_top #(
		.sync_stages(2)
	) i_revo_encoder_top (
		.clock2(clock2),
		.reset(reset),
		.revo_in(revo_in),
		.line_word(line_word),
		.word_load(word_load),
		.clock_gate(clock_gate)
	);

	always #(clock_period / 2) clock2 = ~clock2;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	// fresh marker means activity in the newest 8 samples and none older
	function automatic logic trigger_of(input logic [15:0] history);
		logic [7:0] newer;
		logic [7:0] older;
		newer = history[7:0];
		older = history[15:8];
		return (newer != 8'h00) && (older == 8'h00);
	endfunction

	function automatic revo_pkg::line_word_t word_of(input logic trigger);
		if (trigger) begin
			return 8'b00111111;
		end else begin
			return 8'b11000000;
		end
	endfunction

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic send_pulse(input int len);
		@(posedge clock2);
		revo_in <= 1'b1;
		repeat (len) @(posedge clock2);
		revo_in <= 1'b0;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge clock2);
	endtask

	// ------------------------------------------------------------------------
	// cycle model
	// ------------------------------------------------------------------------

	always @(posedge clock2) begin
		if (reset) begin
			in_delay <= '0;
			exp_marker <= 1'b0;
			high_count <= 0;
			exp_stream <= '0;
			snapshot <= '0;
			frame_cycle <= 0;
			exp_trg <= 1'b0;
			exp_load <= 1'b0;
			exp_gate <= 1'b1;
		end else begin
			in_delay <= {in_delay[0], revo_in};
			// input three cycles late, held high at least three cycles
			if (in_delay[1]) begin
				exp_marker <= 1'b1;
				high_count <= exp_marker ? high_count + 1 : 1;
			end else if (exp_marker && high_count < 3) begin
				exp_marker <= 1'b1;
				high_count <= high_count + 1;
			end else begin
				exp_marker <= 1'b0;
				high_count <= 0;
			end
			exp_stream <= {exp_stream[14:0], exp_marker};
			// verdict on last frame's snapshot, then a new snapshot
			if (frame_cycle % revo_pkg::frame_len == 0) begin
				exp_trg <= trigger_of(snapshot);
				snapshot <= exp_stream;
			end
			exp_load <= (frame_cycle % revo_pkg::frame_len == 1);
			exp_gate <= ~exp_trg;
			frame_cycle <= frame_cycle + 1;
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clock2) begin
		if (!reset) begin
			check_value("word_load", 32'(word_load), 32'(exp_load));
			check_value("clock_gate", 32'(clock_gate), 32'(exp_gate));
			if (word_load) begin
				loads_seen++;
				check_value("line_word", 32'(line_word), 32'(word_of(exp_trg)));
			end
		end
	end

	// ------------------------------------------------------------------------
	// stimulus and report
	// ------------------------------------------------------------------------

	initial begin
		int gap;
		int len;
		errors = 0;
		checks = 0;
		loads_seen = 0;
		lfsr_state = 32'h736e;
		reset = 1'b1;
		revo_in = 1'b0;
		repeat (reset_cycles) @(posedge clock2);
		reset <= 1'b0;

		// quiet line
		idle_cycles(40);
		// isolated short marker
		send_pulse(1);
		idle_cycles(40);
		// long marker that reaches the stale half
		send_pulse(20);
		idle_cycles(40);
		// second marker inside the 16 sample history of the first
		send_pulse(1);
		idle_cycles(min_low + 2);
		send_pulse(2);
		idle_cycles(40);

		for (int i = 0; i < random_pulses; i++) begin
			draw_bits(6, gap);
			draw_bits(4, len);
			send_pulse(len % max_len + 1);
			idle_cycles(min_low + gap % (max_gap + 1));
		end
		idle_cycles(40);

		if (loads_seen == 0) begin
			errors++;
			$display("no word_load strobe was seen during the whole run");
		end
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(limit_cycles * clock_period);
		$display("timeout: the stimulus did not finish within %0d cycles", limit_cycles);
		$display("errors: %0d, checks: %0d", errors, checks);
		$display("Verification failed");
		$finish;
	end

endmodule
